/* all.f */
hw/uncache_pkg.sv
hw/data_uncache.sv
hw/axi_sram.sv
hw/uncache_subsystem.sv
verification/uncache_assertions.sv
verification/uncache_tb.sv

/* hw/axi_sram.sv */
`timescale 1ns/1ns

module axi_sram import uncache_pkg::*; (
    input  logic                  aclk,
    input  logic                  reset,

    // read address
    input  logic [ADDR_W-1:0]     araddr,
    input  logic [BUS_SIZE_W-1:0] arsize,
    input  logic                  arvalid,
    output logic                  arready,

    // read data
    output logic [DATA_W-1:0]     rdata,
    output logic [RESP_W-1:0]     rresp,
    output logic                  rvalid,
    input  logic                  rready,

    // write address and data
    input  logic [ADDR_W-1:0]     awaddr,
    input  logic [BUS_SIZE_W-1:0] awsize,
    input  logic                  awvalid,
    input  logic [DATA_W-1:0]     wdata,
    input  logic [STRB_W-1:0]     wstrb,
    input  logic                  wvalid,
    output logic                  awready,
    output logic                  wready,

    // write response
    output logic [RESP_W-1:0]     bresp,
    output logic                  bvalid,
    input  logic                  bready
);

    logic [DATA_W-1:0] mem [RAM_WORDS];

    logic idle;
    logic rd_fire;
    logic wr_fire;
    logic rd_ok;
    logic wr_ok;

    logic [RAM_ADDR_W-1:0] rd_index;
    logic [RAM_ADDR_W-1:0] wr_index;

    // inside the window and aligned to its own size
    function automatic logic access_ok(input logic [ADDR_W-1:0] addr,
                                       input logic [BUS_SIZE_W-1:0] size);
        logic in_window;
        logic aligned;
        in_window = (addr[ADDR_W-1:RAM_WINDOW_BITS] == RAM_BASE[ADDR_W-1:RAM_WINDOW_BITS]);
        case (size)
            3'd0:    aligned = 1'b1;
            3'd1:    aligned = (addr[0] == 1'b0);
            3'd2:    aligned = (addr[1:0] == 2'b00);
            default: aligned = 1'b0;   // wider than the bus
        endcase
        return in_window && aligned;
    endfunction

    // ==============================
    // handshakes
    // ==============================
    assign idle    = !rvalid && !bvalid;
    assign arready = idle;
    // reads win when both address channels show up together
    assign awready = idle && !arvalid && awvalid && wvalid;
    assign wready  = awready;

    assign rd_fire = arvalid && arready;
    assign wr_fire = awvalid && awready && wvalid && wready;

    assign rd_ok    = access_ok(araddr, arsize);
    assign wr_ok    = access_ok(awaddr, awsize);
    assign rd_index = araddr[RAM_ADDR_W+1:2];
    assign wr_index = awaddr[RAM_ADDR_W+1:2];

    // ==============================
    // storage
    // ==============================
    always_ff @(posedge aclk) begin
        if (wr_fire && wr_ok) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wstrb[i]) mem[wr_index][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_fire) begin
            rdata <= rd_ok ? mem[rd_index] : '0;   // no data leaks out on an error
            rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (wr_fire) begin
            bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // ==============================
    // response valids
    // ==============================
    always_ff @(posedge aclk) begin
        if (reset) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

/* hw/data_uncache.sv */
`timescale 1ns/1ns

module data_uncache import uncache_pkg::*; (
    input  logic                  aclk,
    input  logic                  reset,

    // CPU side
    input  logic                  data_req,
    input  logic                  data_wr,
    input  logic [CPU_SIZE_W-1:0] data_size,
    input  logic [ADDR_W-1:0]     data_addr,
    input  logic [DATA_W-1:0]     data_wdata,
    input  logic [STRB_W-1:0]     data_wstrb,
    output logic [DATA_W-1:0]     data_rdata,
    output logic                  data_addr_ok,
    output logic                  data_data_ok,
    output logic                  data_err,

    // read address
    output logic [ADDR_W-1:0]     araddr,
    output logic [BUS_SIZE_W-1:0] arsize,
    output logic                  arvalid,
    input  logic                  arready,

    // read data
    input  logic [DATA_W-1:0]     rdata,
    input  logic [RESP_W-1:0]     rresp,
    input  logic                  rvalid,
    output logic                  rready,

    // write address and data
    output logic [ADDR_W-1:0]     awaddr,
    output logic [BUS_SIZE_W-1:0] awsize,
    output logic                  awvalid,
    output logic [DATA_W-1:0]     wdata,
    output logic [STRB_W-1:0]     wstrb,
    output logic                  wvalid,
    input  logic                  awready,
    input  logic                  wready,

    // write response
    input  logic [RESP_W-1:0]     bresp,
    input  logic                  bvalid,
    output logic                  bready
);

    uncache_state_t state;
    uncache_state_t state_next;

    logic [ADDR_W-1:0]     req_addr;
    logic [BUS_SIZE_W-1:0] req_size;
    logic [DATA_W-1:0]     req_wdata;
    logic [STRB_W-1:0]     req_wstrb;
    logic [DATA_W-1:0]     rdata_q;
    logic                  err_q;

    logic accept;

    assign accept = (state == IDLE) && data_req;

    // ==============================
    // FSM
    // ==============================
    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (data_req) state_next = data_wr ? AW_W : AR;
            AR:      if (arready) state_next = R;
            R:       if (rvalid) state_next = DONE;
            AW_W:    if (awready && wready) state_next = B;
            B:       if (bvalid) state_next = DONE;
            DONE:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // request fields are only looked at in the accept cycle
    always_ff @(posedge aclk) begin
        if (accept) begin
            req_addr  <= data_addr;
            req_size  <= {{(BUS_SIZE_W - CPU_SIZE_W){1'b0}}, data_size};
            req_wdata <= data_wdata;
            req_wstrb <= data_wstrb;
        end
    end

    // response capture, presented to the CPU during DONE
    always_ff @(posedge aclk) begin
        if (state == R && rvalid) begin
            rdata_q <= rdata;
            err_q   <= (rresp != RESP_OKAY);
        end else if (state == B && bvalid) begin
            err_q <= (bresp != RESP_OKAY);
        end
    end

    // ==============================
    // outputs
    // ==============================
    assign data_addr_ok = (state == IDLE);
    assign data_data_ok = (state == DONE);
    assign data_rdata   = rdata_q;
    assign data_err     = err_q;

    assign araddr  = req_addr;
    assign arsize  = req_size;
    assign arvalid = (state == AR);
    assign rready  = (state == R);

    assign awaddr  = req_addr;
    assign awsize  = req_size;
    assign wdata   = req_wdata;
    assign wstrb   = req_wstrb;
    assign awvalid = (state == AW_W);   // address and data go out together
    assign wvalid  = (state == AW_W);
    assign bready  = (state == B);

endmodule

/* hw/uncache_pkg.sv */
package uncache_pkg;

    // ==============================
    // bus and CPU port widths
    // ==============================
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int CPU_SIZE_W = 2;   // 0 byte, 1 halfword, 2 word
    localparam int BUS_SIZE_W = 3;
    localparam int RESP_W     = 2;

    // ==============================
    // memory window
    // ==============================
    localparam int              RAM_WORDS       = 1024;
    localparam int              RAM_ADDR_W      = $clog2(RAM_WORDS);
    localparam logic [ADDR_W-1:0] RAM_BASE      = 32'h1fc1_3000;
    localparam int              RAM_WINDOW_BITS = 12;   // address bits that select within the window

    // ==============================
    // response codes
    // ==============================
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

    // bridge FSM, one request in flight at a time
    typedef enum logic [2:0] {
        IDLE,
        AR,
        R,
        AW_W,
        B,
        DONE
    } uncache_state_t;

endpackage

/* hw/uncache_subsystem.sv */
`timescale 1ns/1ns

module uncache_subsystem import uncache_pkg::*; (
    input  logic                  aclk,
    input  logic                  reset,

    input  logic                  data_req,
    input  logic                  data_wr,
    input  logic [CPU_SIZE_W-1:0] data_size,
    input  logic [ADDR_W-1:0]     data_addr,
    input  logic [DATA_W-1:0]     data_wdata,
    input  logic [STRB_W-1:0]     data_wstrb,
    output logic [DATA_W-1:0]     data_rdata,
    output logic                  data_addr_ok,
    output logic                  data_data_ok,
    output logic                  data_err
);

    // ==============================
    // bus between bridge and memory
    // ==============================
    logic [ADDR_W-1:0]     araddr;
    logic [BUS_SIZE_W-1:0] arsize;
    logic                  arvalid, arready;

    logic [DATA_W-1:0]     rdata;
    logic [RESP_W-1:0]     rresp;
    logic                  rvalid, rready;

    logic [ADDR_W-1:0]     awaddr;
    logic [BUS_SIZE_W-1:0] awsize;
    logic                  awvalid, awready;

    logic [DATA_W-1:0]     wdata;
    logic [STRB_W-1:0]     wstrb;
    logic                  wvalid, wready;

    logic [RESP_W-1:0]     bresp;
    logic                  bvalid, bready;

    data_uncache i_data_uncache (
        .aclk, .reset,
        .data_req, .data_wr, .data_size, .data_addr, .data_wdata, .data_wstrb,
        .data_rdata, .data_addr_ok, .data_data_ok, .data_err,
        .araddr, .arsize, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .awaddr, .awsize, .awvalid, .wdata, .wstrb, .wvalid, .awready, .wready,
        .bresp, .bvalid, .bready
    );

    axi_sram i_axi_sram (
        .aclk, .reset,
        .araddr, .arsize, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .awaddr, .awsize, .awvalid, .wdata, .wstrb, .wvalid, .awready, .wready,
        .bresp, .bvalid, .bready
    );

endmodule

/* verification/uncache_assertions.sv */
`timescale 1ns/1ns

module uncache_assertions import uncache_pkg::*; (
    input logic                  aclk,
    input logic                  reset,
    input logic                  data_req,
    input logic                  data_addr_ok,
    input logic                  data_data_ok,
    input logic [ADDR_W-1:0]     araddr,
    input logic [BUS_SIZE_W-1:0] arsize,
    input logic                  arvalid,
    input logic                  arready,
    input logic                  rvalid,
    input logic                  rready,
    input logic [ADDR_W-1:0]     awaddr,
    input logic [BUS_SIZE_W-1:0] awsize,
    input logic                  awvalid,
    input logic                  awready,
    input logic [DATA_W-1:0]     wdata,
    input logic [STRB_W-1:0]     wstrb,
    input logic                  wvalid,
    input logic                  bvalid,
    input logic                  bready
);

    logic resp_fire;
    int   fail_count = 0;   // read by the testbench at the end of the run

    assign resp_fire = (rvalid && rready) || (bvalid && bready);

    // ==============================
    // bus side
    // ==============================
    ar_hold: assert property (@(posedge aclk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arsize))
    else begin
        $error("arvalid dropped or its payload changed before arready");
        fail_count++;
    end

    aw_hold: assert property (@(posedge aclk) disable iff (reset)
        awvalid && !awready |=> awvalid && wvalid && $stable(awaddr) && $stable(awsize)
            && $stable(wdata) && $stable(wstrb))
    else begin
        $error("awvalid or wvalid dropped or a payload changed before the handshake");
        fail_count++;
    end

    aw_w_pair: assert property (@(posedge aclk) disable iff (reset) awvalid == wvalid)
    else begin
        $error("awvalid and wvalid differ");
        fail_count++;
    end

    // ==============================
    // CPU side
    // ==============================
    data_ok_pulse: assert property (@(posedge aclk) disable iff (reset)
        data_data_ok |=> !data_data_ok)
    else begin
        $error("data_data_ok high for two cycles running");
        fail_count++;
    end

    // low after the accept, and stays low until the data_data_ok pulse has been seen
    addr_ok_low: assert property (@(posedge aclk) disable iff (reset)
        (data_req && data_addr_ok) || (!data_addr_ok && !data_data_ok) |=> !data_addr_ok)
    else begin
        $error("data_addr_ok rose while a request was still in flight");
        fail_count++;
    end

    data_ok_after_resp: assert property (@(posedge aclk) disable iff (reset)
        data_data_ok == $past(resp_fire))
    else begin
        $error("data_data_ok does not follow the response handshake by one cycle");
        fail_count++;
    end

endmodule

bind data_uncache uncache_assertions i_uncache_assertions (.*);

/* verification/uncache_tb.sv */
`timescale 1ns/1ns

module uncache_tb import uncache_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 50;

    logic                  aclk;
    logic                  reset;
    logic                  data_req;
    logic                  data_wr;
    logic [CPU_SIZE_W-1:0] data_size;
    logic [ADDR_W-1:0]     data_addr;
    logic [DATA_W-1:0]     data_wdata;
    logic [STRB_W-1:0]     data_wstrb;
    logic [DATA_W-1:0]     data_rdata;
    logic                  data_addr_ok;
    logic                  data_data_ok;
    logic                  data_err;

    logic [DATA_W-1:0] shadow [RAM_WORDS];   // what the memory should hold
    int    seed = 32'h9da0124f;
    string test_name;
    int    check_errors = 0;
    int    errors_at_start = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    last_latency = 0;   // cycles from accept to data_data_ok

    uncache_subsystem i_uncache_subsystem (.*);

    initial aclk = 1'b0;
    always #4 aclk = ~aclk;

    // ==============================
    // reference rules
    // ==============================
    function automatic logic access_allowed(input logic [ADDR_W-1:0] addr,
                                            input logic [CPU_SIZE_W-1:0] size);
        logic inside_window;
        inside_window = (addr[ADDR_W-1:RAM_WINDOW_BITS] == RAM_BASE[ADDR_W-1:RAM_WINDOW_BITS]);
        if (size == 2'd1) return inside_window && !addr[0];
        if (size == 2'd2) return inside_window && (addr[1:0] == 2'b00);
        return inside_window && (size == 2'd0);
    endfunction

    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        return {addr[7:0], addr[31:8]} ^ 32'h5a5a_c3c3;
    endfunction

    task automatic check_value(input string what, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED test %s (%s): expected %h, actual %h",
                     test_name, what, expected, actual);
            check_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = check_errors;
    endtask

    task automatic finish_test();
        if (check_errors == errors_at_start) begin
            tests_passed++;
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, check_errors - errors_at_start);
        end
    endtask

    // one CPU request, checked against the shadow memory
    task automatic bus_access(input logic wr, input logic [CPU_SIZE_W-1:0] size,
                              input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                              input logic [STRB_W-1:0] strb);
        logic                  ok;
        logic                  accepted;
        logic [DATA_W-1:0]     expected;
        logic [RAM_ADDR_W-1:0] index;
        int                    waited;
        ok       = access_allowed(addr, size);
        index    = addr[RAM_ADDR_W+1:2];
        expected = ok ? shadow[index] : '0;
        @(posedge aclk);
        data_req   <= 1'b1;
        data_wr    <= wr;
        data_size  <= size;
        data_addr  <= addr;
        data_wdata <= wdata;
        data_wstrb <= strb;
        waited = 0;
        @(negedge aclk);
        while (!data_addr_ok && waited < TIMEOUT_CYCLES) begin
            @(negedge aclk);
            waited++;
        end
        accepted = data_addr_ok;   // the request is taken at the next rising edge
        @(posedge aclk);
        data_req <= 1'b0;
        if (!accepted) begin
            $display("timeout in test %s: data_addr_ok never came back high", test_name);
            check_errors++;
        end else begin
            last_latency = 0;
            do begin
                @(negedge aclk);
                last_latency++;
            end while (!data_data_ok && last_latency < TIMEOUT_CYCLES);
            if (!data_data_ok) begin
                $display("timeout in test %s: data_data_ok never pulsed", test_name);
                check_errors++;
            end else begin
                check_value("data_err", !ok, data_err);
                if (!wr) check_value("read data", expected, data_rdata);
                if (wr && ok) begin
                    for (int i = 0; i < STRB_W; i++) begin
                        if (strb[i]) shadow[index][8*i +: 8] = wdata[8*i +: 8];
                    end
                end
            end
        end
    endtask

    task automatic random_access();
        logic [31:0]           r;
        logic [CPU_SIZE_W-1:0] size;
        logic [ADDR_W-1:0]     addr;
        logic [STRB_W-1:0]     strb;
        r    = $random(seed);
        size = (r[7:0] % 3 == 0) ? 2'd0 : ((r[7:0] % 3 == 1) ? 2'd1 : 2'd2);
        addr = RAM_BASE | (r[31:16] & 32'hffc);
        case (size)
            2'd0: begin
                addr[1:0] = r[9:8];
                strb = 4'b0001 << r[9:8];
            end
            2'd1: begin
                addr[1] = r[10];
                strb = r[10] ? 4'b1100 : 4'b0011;
            end
            default: strb = r[14:11];   // word writes may leave lanes untouched
        endcase
        r = $random(seed);
        if (r[15:0] % 10 == 0) addr[ADDR_W-1:RAM_WINDOW_BITS] ^= {r[31:13], 1'b1};
        bus_access(r[16], size, addr, $random(seed), strb);
    endtask

    // ==============================
    // test sequence
    // ==============================
    initial begin
        logic [ADDR_W-1:0] addr;
        int                bound_fails;
        data_req   = 1'b0;
        data_wr    = 1'b0;
        data_size  = '0;
        data_addr  = '0;
        data_wdata = '0;
        data_wstrb = '0;
        reset      = 1'b1;
        repeat (4) @(posedge aclk);
        reset <= 1'b0;

        start_test("reset_state");
        @(negedge aclk);
        check_value("data_addr_ok", 1'b1, data_addr_ok);
        check_value("data_data_ok", 1'b0, data_data_ok);
        finish_test();

        start_test("fill");
        for (int i = 0; i < RAM_WORDS; i++) begin
            addr = RAM_BASE + 32'(4 * i);
            bus_access(1'b1, 2'd2, addr, fill_word(addr), 4'hf);
        end
        finish_test();

        start_test("word_write_read");
        addr = RAM_BASE + 32'h240;
        bus_access(1'b1, 2'd2, addr, 32'hdead_beef, 4'hf);
        check_value("write latency", 3, last_latency);
        bus_access(1'b0, 2'd2, addr, '0, 4'hf);
        check_value("read latency", 3, last_latency);
        finish_test();

        start_test("lane_merge");
        addr = RAM_BASE + 32'h3c0;
        bus_access(1'b1, 2'd2, addr, 32'h1122_3344, 4'hf);
        bus_access(1'b1, 2'd0, addr + 1, 32'h0000_ab00, 4'b0010);
        bus_access(1'b1, 2'd1, addr + 2, 32'hcdef_0000, 4'b1100);
        bus_access(1'b0, 2'd2, addr, '0, 4'hf);
        check_value("merged word", 32'hcdef_ab44, data_rdata);
        finish_test();

        start_test("error_responses");
        addr = RAM_BASE + 32'h124;
        bus_access(1'b1, 2'd2, addr ^ 32'h0040_0000, 32'h5555_5555, 4'hf);   // same index
        bus_access(1'b0, 2'd2, addr ^ 32'h0040_0000, '0, 4'hf);
        bus_access(1'b1, 2'd1, addr + 1, 32'h6666_6666, 4'b0110);
        bus_access(1'b1, 2'd2, addr + 2, 32'h7777_7777, 4'hf);
        bus_access(1'b0, 2'd2, addr, '0, 4'hf);
        check_value("unchanged word", fill_word(addr), data_rdata);
        finish_test();

        start_test("random_mix");
        repeat (200) random_access();
        finish_test();

        bound_fails = i_uncache_subsystem.i_data_uncache.i_uncache_assertions.fail_count;
        $display("tests passed %0d, tests failed %0d, protocol assertion failures %0d",
                 tests_passed, tests_failed, bound_fails);
        if (tests_failed == 0 && bound_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
